// ==== rtl/bgLoadCfg.svh ====
`ifndef BG_LOAD_CFG_SVH
`define BG_LOAD_CFG_SVH

// external sram word address width
`define BG_SRAM_AW 20

// frame buffer address width, kept small for simulation
`define BG_FB_AW 8

// frame buffer words, also the longest image that fits
`define BG_FB_DEPTH (1 << `BG_FB_AW)

// distance between background bases in sram
// one extra word per slot holds the end marker
`define BG_SLOT_WORDS (`BG_FB_DEPTH + 1)

// marker threshold, any word strictly above it ends the image
`define BG_END_MARK 16'hF000

// cycles output enable is held low before the bus is sampled
`define BG_SRAM_WAIT 2

`endif

// ==== rtl/bgLoadPkg.sv ====
package bgLoadPkg;

	// one 16-bit pixel word, as stored in sram and in the frame buffer
	typedef logic [15:0] pixelWordT;

	// loader FSM
	// settle gives the slot base one cycle to land before the first read
	typedef enum logic [2:0] {
		ldIdle,
		ldSettle,
		ldRead,
		ldWrite,
		ldDone
	} loadStateT;

	// sram read sequencer
	typedef enum logic [1:0] {
		srIdle,
		srAccess,
		srCapture
	} sramStateT;

endpackage

// ==== rtl/sramReader.sv ====
`include "bgLoadCfg.svh"

module sramReader (
	input  logic                   Clk,
	input  logic                   rstN,
	input  logic                   readReq,
	input  logic [`BG_SRAM_AW-1:0] readAddr,
	input  bgLoadPkg::pixelWordT   sramData,
	output logic [`BG_SRAM_AW-1:0] sramAddr,
	output logic                   sramOeN,
	output bgLoadPkg::pixelWordT   readData,
	output logic                   dataValid
);

	import bgLoadPkg::*;

	// counter wide enough to reach the last wait cycle
	localparam int waitW = $clog2(`BG_SRAM_WAIT + 1);
	localparam logic [waitW-1:0] lastWait = waitW'(`BG_SRAM_WAIT - 1);

	sramStateT        state;
	logic [waitW-1:0] waitCnt;

	// control side: state, output enable, wait counter, valid strobe
	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			state     <= srIdle;
			sramOeN   <= 1'b1;
			waitCnt   <= '0;
			dataValid <= 1'b0;
		end
		else
		begin
			case (state)
				srIdle:
				begin
					dataValid <= 1'b0;
					if (readReq)
					begin
						// drive the pins on the same edge as the address
						state   <= srAccess;
						sramOeN <= 1'b0;
						waitCnt <= '0;
					end
				end
				srAccess:
				begin
					if (waitCnt == lastWait)
					begin
						// access window over, release the bus
						state     <= srCapture;
						sramOeN   <= 1'b1;
						dataValid <= 1'b1;
					end
					else
						waitCnt <= waitCnt + 1'b1;
				end
				srCapture:
				begin
					// valid only lasts the one cycle
					state     <= srIdle;
					dataValid <= 1'b0;
				end
				default:
				begin
					state     <= srIdle;
					sramOeN   <= 1'b1;
					dataValid <= 1'b0;
				end
			endcase
		end
	end

	// address and data registers, no reset needed
	always_ff @(posedge Clk)
	begin
		if (state == srIdle && readReq)
			sramAddr <= readAddr;
		// sample the bus on the last edge with oe still low
		if (state == srAccess && waitCnt == lastWait)
			readData <= sramData;
	end

	// a valid strobe is a single cycle
	assert property (@(posedge Clk) disable iff (!rstN) dataValid |=> !dataValid);

	// the bus was enabled right before the data is presented
	assert property (@(posedge Clk) disable iff (!rstN) dataValid |-> $past(!sramOeN));

endmodule

// ==== rtl/backgroundLoader.sv ====
`include "bgLoadCfg.svh"

module backgroundLoader (
	input  logic                   Clk,
	input  logic                   rstN,
	input  logic                   load,
	input  logic [1:0]             bgSel,
	input  bgLoadPkg::pixelWordT   readData,
	input  logic                   dataValid,
	output logic                   readReq,
	output logic [`BG_SRAM_AW-1:0] readAddr,
	output logic                   fbWe,
	output logic [`BG_FB_AW-1:0]   fbAddr,
	output bgLoadPkg::pixelWordT   fbData,
	output logic                   busy,
	output logic                   loadDone
);

	import bgLoadPkg::*;

	// last frame buffer slot, a write here ends the load
	localparam logic [`BG_FB_AW-1:0] lastFbAddr = `BG_FB_AW'(`BG_FB_DEPTH - 1);

	loadStateT              state;
	loadStateT              nextState;
	logic [1:0]             bgSelQ;
	logic [`BG_SRAM_AW-1:0] readAddrQ;
	logic [`BG_FB_AW-1:0]   fbAddrQ;
	pixelWordT              dataQ;
	logic                   isMarker;

	// strictly greater, a word equal to the threshold is still pixel data
	assign isMarker = readData > `BG_END_MARK;

	always_ff @(posedge Clk)
	begin
		if (!rstN)
			state <= ldIdle;
		else
			state <= nextState;
	end

	// walk read/write until a marker or a full buffer
	always_comb
	begin
		nextState = state;
		case (state)
			ldIdle:
				if (load)
					nextState = ldSettle;
			ldSettle:
				nextState = ldRead;
			ldRead:
			begin
				if (dataValid)
				begin
					if (isMarker)
						nextState = ldDone;
					else
						nextState = ldWrite;
				end
			end
			ldWrite:
			begin
				// out of room, finish as if a marker was read
				if (fbAddrQ == lastFbAddr)
					nextState = ldDone;
				else
					nextState = ldRead;
			end
			ldDone:
				nextState = ldIdle;
			default:
				nextState = ldIdle;
		endcase
	end

	// address walk and word hold
	always_ff @(posedge Clk)
	begin
		case (state)
			ldIdle:
			begin
				if (load)
				begin
					bgSelQ  <= bgSel;
					fbAddrQ <= '0;
				end
			end
			ldSettle:
				// slot base from the latched selection
				readAddrQ <= `BG_SRAM_AW'(bgSelQ) * `BG_SRAM_AW'(`BG_SLOT_WORDS);
			ldRead:
				if (dataValid)
					dataQ <= readData;
			ldWrite:
			begin
				// next sram word and next buffer slot
				readAddrQ <= readAddrQ + 1'b1;
				fbAddrQ   <= fbAddrQ + 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	// request stays up for the whole read state, so the address is stable
	assign readReq  = state == ldRead;
	assign readAddr = readAddrQ;

	// one write strobe per stored word
	assign fbWe   = state == ldWrite;
	assign fbAddr = fbAddrQ;
	assign fbData = dataQ;

	assign busy     = state != ldIdle;
	assign loadDone = state == ldDone;

	// every write follows a word accepted from the reader
	assert property (@(posedge Clk) disable iff (!rstN)
		fbWe |-> $past(dataValid));

	// request was up in the cycle before each write
	assert property (@(posedge Clk) disable iff (!rstN)
		state == ldWrite |-> $past(readReq));

	// done is a single pulse and the loader is free right after
	assert property (@(posedge Clk) disable iff (!rstN)
		loadDone |=> !loadDone && !busy);

endmodule

// ==== rtl/frameBuffer.sv ====
`include "bgLoadCfg.svh"

module frameBuffer (
	input  logic                 Clk,
	input  logic                 fbWe,
	input  logic [`BG_FB_AW-1:0] fbAddr,
	input  bgLoadPkg::pixelWordT fbData,
	input  logic [`BG_FB_AW-1:0] pixelAddr,
	output bgLoadPkg::pixelWordT pixelData
);

	import bgLoadPkg::*;

	// one word per pixel slot
	// contents carry over from one load to the next
	pixelWordT mem [`BG_FB_DEPTH];

	// loader side, one write per strobe
	always_ff @(posedge Clk)
	begin
		if (fbWe)
			mem[fbAddr] <= fbData;
	end

	// display side, registered read
	// data shows up the cycle after the address
	always_ff @(posedge Clk)
	begin
		pixelData <= mem[pixelAddr];
	end

endmodule

// ==== rtl/bgLoadTop.sv ====
`include "bgLoadCfg.svh"

module bgLoadTop (
	input  logic                   Clk,
	input  logic                   rstN,
	input  logic                   load,
	input  logic [1:0]             bgSel,
	input  bgLoadPkg::pixelWordT   sramData,
	output logic [`BG_SRAM_AW-1:0] sramAddr,
	output logic                   sramOeN,
	input  logic [`BG_FB_AW-1:0]   pixelAddr,
	output bgLoadPkg::pixelWordT   pixelData,
	output logic                   busy,
	output logic                   loadDone
);

	import bgLoadPkg::*;

	// loader to reader
	logic                   readReq;
	logic [`BG_SRAM_AW-1:0] readAddr;
	pixelWordT              readData;
	logic                   dataValid;

	// loader to frame buffer
	logic                   fbWe;
	logic [`BG_FB_AW-1:0]   fbAddr;
	pixelWordT              fbData;

	// sram pin sequencing
	sramReader uReader (
		.Clk       (Clk),
		.rstN      (rstN),
		.readReq   (readReq),
		.readAddr  (readAddr),
		.sramData  (sramData),
		.sramAddr  (sramAddr),
		.sramOeN   (sramOeN),
		.readData  (readData),
		.dataValid (dataValid)
	);

	// slot walk and marker detect
	backgroundLoader uLoader (
		.Clk       (Clk),
		.rstN      (rstN),
		.load      (load),
		.bgSel     (bgSel),
		.readData  (readData),
		.dataValid (dataValid),
		.readReq   (readReq),
		.readAddr  (readAddr),
		.fbWe      (fbWe),
		.fbAddr    (fbAddr),
		.fbData    (fbData),
		.busy      (busy),
		.loadDone  (loadDone)
	);

	// image store, read back by the display
	frameBuffer uFrameBuffer (
		.Clk       (Clk),
		.fbWe      (fbWe),
		.fbAddr    (fbAddr),
		.fbData    (fbData),
		.pixelAddr (pixelAddr),
		.pixelData (pixelData)
	);

endmodule

// ==== verif/bgLoadTb.sv ====
`include "bgLoadCfg.svh"

module bgLoadTb;

	timeunit 1ns;
	timeprecision 100ps;

	import bgLoadPkg::*;

	localparam int slotWords = `BG_SLOT_WORDS;
	localparam int fbDepth = `BG_FB_DEPTH;
	localparam int memWords = 4 * slotWords;
	localparam logic [31:0] lfsrSeed = 32'h11814068;
	// generous bound, one word costs well under ten cycles
	localparam int doneTimeout = 10 * slotWords;
	localparam time simLimit = 5ms;

	logic                   Clk;
	logic                   rstN;
	logic                   load;
	logic [1:0]             bgSel;
	pixelWordT              sramData;
	logic [`BG_SRAM_AW-1:0] sramAddr;
	logic                   sramOeN;
	logic [`BG_FB_AW-1:0]   pixelAddr;
	pixelWordT              pixelData;
	logic                   busy;
	logic                   loadDone;

	// sram image store, four slots back to back
	pixelWordT sramMem [memWords];
	// what the frame buffer should hold after the last load
	pixelWordT expFb [fbDepth];

	bgLoadTop uut (
		.Clk       (Clk),
		.rstN      (rstN),
		.load      (load),
		.bgSel     (bgSel),
		.sramData  (sramData),
		.sramAddr  (sramAddr),
		.sramOeN   (sramOeN),
		.pixelAddr (pixelAddr),
		.pixelData (pixelData),
		.busy      (busy),
		.loadDone  (loadDone)
	);

	// asynchronous sram, data only while output enable is low
	assign sramData = !sramOeN ? sramMem[sramAddr] : 'x;

	initial
	begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	// 32-bit galois lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// expected word at one buffer address after loading slot sel
	// a marker at or before addr leaves the old word in place
	function automatic pixelWordT expectedWord(input int sel, input int addr,
		input pixelWordT prevWord);
		int base;
		base = sel * slotWords;
		for (int i = 0; i <= addr; i++)
		begin
			if (sramMem[base + i] > `BG_END_MARK)
				return prevWord;
		end
		return sramMem[base + addr];
	endfunction

	task automatic failWith(input string msg);
		$display("%s", msg);
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic checkPixel(input string name, input int addr, input pixelWordT expVal,
		input pixelWordT actVal);
		if (actVal !== expVal)
		begin
			$display("FAILED at %0t: %s[%0d] expected %h, got %h",
				$time, name, addr, expVal, actVal);
			failWith("frame buffer readback mismatch");
		end
	endtask

	task automatic checkFlag(input string name, input logic expVal, input logic actVal);
		if (actVal !== expVal)
		begin
			$display("FAILED at %0t: %s expected %b, got %b", $time, name, expVal, actVal);
			failWith("control flag mismatch");
		end
	endtask

	// one bit per lfsr step, fill words clamped below the marker
	task automatic fillSram();
		logic [31:0] lfsr;
		pixelWordT   w;
		lfsr = lfsrSeed;
		for (int a = 0; a < memWords; a++)
		begin
			for (int b = 0; b < 16; b++)
			begin
				lfsr = lfsrStep(lfsr);
				w[b] = lfsr[0];
			end
			if (w > `BG_END_MARK)
				w = w & 16'h7FFF;
			sramMem[a] = w;
		end
	endtask

	task automatic startLoad(input logic [1:0] sel);
		@(posedge Clk);
		load  <= 1'b1;
		bgSel <= sel;
		@(posedge Clk);
		load  <= 1'b0;
		@(negedge Clk);
		checkFlag("busy", 1'b1, busy);
	endtask

	// done pulse, then loader free on the next cycle
	task automatic waitDone();
		int cycles;
		cycles = 0;
		while (loadDone !== 1'b1 && cycles < doneTimeout)
		begin
			@(negedge Clk);
			cycles++;
		end
		if (loadDone !== 1'b1)
			failWith("loadDone never arrived, load timed out");
		@(negedge Clk);
		checkFlag("loadDone", 1'b0, loadDone);
		checkFlag("busy", 1'b0, busy);
	endtask

	// read back every address, registered port so sample a cycle later
	task automatic checkBuffer(input int sel);
		pixelWordT expVal;
		for (int a = 0; a < fbDepth; a++)
		begin
			expVal = expectedWord(sel, a, expFb[a]);
			@(posedge Clk);
			pixelAddr <= a[`BG_FB_AW-1:0];
			@(posedge Clk);
			@(negedge Clk);
			checkPixel("pixelData", a, expVal, pixelData);
			expFb[a] = expVal;
		end
	endtask

	// hard stop in case a wait slips through
	initial
	begin
		#(simLimit);
		failWith("simulation ran past its time limit");
	end

	initial
	begin
		rstN      = 1'b0;
		load      = 1'b0;
		bgSel     = 2'd0;
		pixelAddr = '0;
		fillSram();
		// slot 0 ends after 37 words
		sramMem[0 * slotWords + 37] = 16'hFFFF;
		// slot 1 holds an exact threshold word, real marker at 100
		sramMem[1 * slotWords + 20] = `BG_END_MARK;
		sramMem[1 * slotWords + 100] = 16'hF001;
		// slot 2 is empty
		sramMem[2 * slotWords] = 16'hF800;
		// slot 3 has no marker and fills the whole buffer

		repeat (8) @(posedge Clk);
		rstN <= 1'b1;
		@(negedge Clk);
		checkFlag("sramOeN", 1'b1, sramOeN);
		checkFlag("busy", 1'b0, busy);
		checkFlag("loadDone", 1'b0, loadDone);

		// full image first, every address becomes known
		startLoad(2'd3);
		waitDone();
		checkBuffer(3);

		startLoad(2'd1);
		waitDone();
		checkBuffer(1);

		// second load pulse mid-transfer must be dropped
		startLoad(2'd0);
		repeat (4) @(posedge Clk);
		load  <= 1'b1;
		bgSel <= 2'd1;
		@(posedge Clk);
		load  <= 1'b0;
		waitDone();
		checkBuffer(0);

		startLoad(2'd2);
		waitDone();
		checkBuffer(2);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/bgLoadPkg.sv
rtl/sramReader.sv
rtl/backgroundLoader.sv
rtl/frameBuffer.sv
rtl/bgLoadTop.sv
verif/bgLoadTb.sv

// ==== run.sh ====
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f tb.f --top-module bgLoadTb -o bgLoadSim \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/bgLoadSim > sim.log 2>&1
cat sim.log
grep -q "^STATUS: PASS$" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
